// ==== vlog.f ====
cic_pkg.sv
cic_comb.sv
cic_strober.sv
cic_integrator.sv
cic_round.sv
cic_interpolate.sv
rate_config.sv
cic_interp_top.sv
tb_cic_interp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_cic_interp -f vlog.f &&
./obj_dir/Vtb_cic_interp | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }

// ==== tb_cic_interp.sv ====
// Testbench for the CIC interpolation subsystem
// Table-driven rate loads, sample streams and settled level checks
`timescale 1ns/10ps

module tb_cic_interp;

  localparam int WIDTH = 16;
  localparam int N = 4;
  localparam int MAX_RATE = 128;
  localparam int RW = cic_pkg::rate_bits(MAX_RATE);
  localparam int FLUSH = 2 * N;
  localparam int QUIET = 24;
  localparam int ACK_TIMEOUT = 16;
  localparam int NUM_ROWS = 10;

  typedef struct {
    int               rate;
    logic [WIDTH-1:0] level;
    int               samples;
    int               discard;
    logic [WIDTH-1:0] expected;
    bit               random_level;
  } row_t;

  logic             clk = 1'b0;
  logic             reset;
  logic             strobe_in;
  logic [WIDTH-1:0] signal_in;
  logic             strobe_out;
  logic [WIDTH-1:0] signal_out;
  logic             rate_req;
  logic [RW-1:0]    rate_value;
  logic             rate_ack;

  row_t             rows [NUM_ROWS];
  logic [WIDTH-1:0] out_q [$];
  logic [31:0]      lcg_state;
  bit               collecting;
  bit               timed_out;
  int               strobe_count;
  int               mismatch_count;
  int               other_count;

  cic_interp_top #(.WIDTH(WIDTH), .N(N), .MAX_RATE(MAX_RATE)) dut (
    .clk        (clk),
    .reset      (reset),
    .strobe_in  (strobe_in),
    .signal_in  (signal_in),
    .strobe_out (strobe_out),
    .signal_out (signal_out),
    .rate_req   (rate_req),
    .rate_value (rate_value),
    .rate_ack   (rate_ack)
  );

  always #4 clk = ~clk;

  // Output monitor on the falling edge, away from the drive point
  always @(negedge clk) begin
    if (!reset && strobe_out) begin
      strobe_count = strobe_count + 1;
      if (collecting) begin
        out_q.push_back(signal_out);
      end
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // DC model: gain rate**(N-1), then round half up and saturate
  function automatic logic [WIDTH-1:0] settled_value(input int rate, input logic [WIDTH-1:0] level);
    longint gain;
    longint acc;
    longint max_val;
    int     shift;
    gain = 1;
    shift = 0;
    max_val = (longint'(1) << (WIDTH - 1)) - 1;
    for (int i = 1; i < N; i++) begin
      gain = gain * longint'(rate);
    end
    while ((longint'(1) << shift) < gain) begin
      shift = shift + 1;
    end
    acc = longint'($signed(level)) * gain;
    if (cic_pkg::round_half && shift > 0) begin
      acc = acc + (longint'(1) << (shift - 1));
    end
    acc = acc >>> shift;
    if (acc > max_val) begin
      return {1'b0, {(WIDTH-1){1'b1}}};
    end else if (acc < -max_val - 1) begin
      return {1'b1, {(WIDTH-1){1'b0}}};
    end
    return WIDTH'(acc);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      mismatch_count = mismatch_count + 1;
      $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    other_count = other_count + 1;
    $display("%s", msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Four-phase handshake on the rate port
  task automatic load_rate(input int rate);
    int cycles;
    cycles = 0;
    check_value("rate_ack", 32'd0, 32'(rate_ack));
    rate_value = RW'(rate);
    rate_req = 1'b1;
    while (!rate_ack && cycles < ACK_TIMEOUT) begin
      next_cycle();
      cycles = cycles + 1;
    end
    if (!rate_ack) begin
      report_failure($sformatf("Timeout waiting for rate_ack to rise, rate %0d", rate));
      timed_out = 1'b1;
    end else begin
      repeat (3) begin
        next_cycle();
        check_value("rate_ack", 32'd1, 32'(rate_ack));
      end
      rate_req = 1'b0;
      cycles = 0;
      while (rate_ack && cycles < ACK_TIMEOUT) begin
        next_cycle();
        cycles = cycles + 1;
      end
      if (rate_ack) begin
        report_failure($sformatf("Timeout waiting for rate_ack to fall, rate %0d", rate));
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic feed_samples(input int rate, input logic [WIDTH-1:0] level, input int count);
    for (int i = 0; i < count; i++) begin
      strobe_in = 1'b1;
      signal_in = level;
      next_cycle();
      strobe_in = 1'b0;
      repeat (rate - 1) next_cycle();
    end
  endtask

  task automatic wait_idle(input int rate);
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    while (quiet < QUIET && cycles < 4 * rate + 8 * QUIET) begin
      next_cycle();
      cycles = cycles + 1;
      quiet = strobe_out ? 0 : quiet + 1;
    end
    if (quiet < QUIET) begin
      report_failure($sformatf("Output strobes did not stop at rate %0d", rate));
      timed_out = 1'b1;
    end
  endtask

  task automatic run_row(input row_t row);
    load_rate(row.rate);
    if (!timed_out) begin
      strobe_count = 0;
      out_q.delete();
      collecting = 1'b1;
      feed_samples(row.rate, row.level, row.samples);
      collecting = 1'b0;
      // Zero samples return every stage to rest before the next rate
      feed_samples(row.rate, '0, FLUSH);
      wait_idle(row.rate);
    end
    if (!timed_out) begin
      check_value("strobe_count", 32'((row.samples + FLUSH) * row.rate), 32'(strobe_count));
      if (out_q.size() <= row.discard) begin
        report_failure($sformatf("Too few settled outputs at rate %0d", row.rate));
      end else begin
        for (int i = row.discard; i < out_q.size(); i++) begin
          check_value("signal_out", 32'(row.expected), 32'(out_q[i]));
        end
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    strobe_in = 1'b0;
    signal_in = '0;
    rate_req = 1'b0;
    rate_value = RW'(1);
    collecting = 1'b0;
    timed_out = 1'b0;
    strobe_count = 0;
    mismatch_count = 0;
    other_count = 0;
    lcg_state = 32'h9c02_d05f;
    // rate, level, samples, discarded outputs, settled output, random level
    rows[0] = '{1, 16'h1234, 30, 8, 16'h1234, 1'b0};
    rows[1] = '{4, 16'h7fff, 16, 20, 16'h7fff, 1'b0};
    rows[2] = '{8, 16'h8000, 12, 36, 16'h8000, 1'b0};
    rows[3] = '{64, 16'hb7e1, 8, 260, 16'hb7e1, 1'b0};
    rows[4] = '{2, 16'h0000, 16, 12, 16'h0000, 1'b1};
    rows[5] = '{16, 16'h0000, 10, 68, 16'h0000, 1'b1};
    rows[6] = '{1, 16'hc350, 30, 8, 16'hc350, 1'b0};
    rows[7] = '{8, 16'h0000, 12, 36, 16'h0000, 1'b1};
    rows[8] = '{4, 16'h0001, 16, 20, 16'h0001, 1'b0};
    rows[9] = '{128, 16'h7fff, 6, 516, 16'h7fff, 1'b0};
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].random_level) begin
        lcg_state = lcg_next(lcg_state);
        rows[r].level = lcg_state[31:16];
        rows[r].expected = settled_value(rows[r].rate, rows[r].level);
      end
    end
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    next_cycle();
    check_value("strobe_out", 32'd0, 32'(strobe_out));
    check_value("rate_ack", 32'd0, 32'(rate_ack));
    check_value("signal_out", 32'd0, 32'(signal_out));
    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      run_row(rows[r]);
    end
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== cic_interp_top.sv ====
// CIC interpolation subsystem top level
// Rate configuration port in front of the interpolator core
`timescale 1ns/10ps

module cic_interp_top #(
  parameter int WIDTH = cic_pkg::DEF_WIDTH,
  parameter int N = cic_pkg::DEF_N,
  parameter int MAX_RATE = cic_pkg::DEF_MAX_RATE
)(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    strobe_in,
  input  logic [WIDTH-1:0]                        signal_in,
  output logic                                    strobe_out,
  output logic [WIDTH-1:0]                        signal_out,
  input  logic                                    rate_req,
  input  logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate_value,
  output logic                                    rate_ack
);

  logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate;
  logic                                    rate_stb;

  rate_config #(.MAX_RATE(MAX_RATE)) u_rate_config (
    .clk        (clk),
    .reset      (reset),
    .rate_req   (rate_req),
    .rate_value (rate_value),
    .rate_ack   (rate_ack),
    .rate       (rate),
    .rate_stb   (rate_stb)
  );

  cic_interpolate #(.WIDTH(WIDTH), .N(N), .MAX_RATE(MAX_RATE)) u_interpolate (
    .clk        (clk),
    .reset      (reset),
    .rate       (rate),
    .rate_stb   (rate_stb),
    .strobe_in  (strobe_in),
    .signal_in  (signal_in),
    .strobe_out (strobe_out),
    .signal_out (signal_out)
  );

endmodule

// ==== rate_config.sv ====
// Rate configuration port
// Four-phase req/ack slave that loads a new interpolation rate
`timescale 1ns/10ps

module rate_config #(
  parameter int MAX_RATE = 128
)(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    rate_req,
  input  logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate_value,
  output logic                                    rate_ack,
  output logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate,
  output logic                                    rate_stb
);

  localparam int RW = cic_pkg::rate_bits(MAX_RATE);

  localparam logic st_idle = 1'b0;
  localparam logic st_ack  = 1'b1;

  logic state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      rate     <= RW'(1);
      rate_stb <= 1'b0;
    end else begin
      rate_stb <= 1'b0;
      case (state)
        st_idle: begin
          if (rate_req) begin
            rate     <= rate_value;
            rate_stb <= 1'b1;
            state    <= st_ack;
          end
        end
        st_ack: begin
          // Hold ack until the host withdraws the request
          if (!rate_req) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign rate_ack = (state == st_ack);

endmodule

// ==== cic_interpolate.sv ====
// CIC interpolator core
// Comb, strober, integrator and rounding with a registered output
`timescale 1ns/10ps

module cic_interpolate #(
  parameter int WIDTH = 16,
  parameter int N = 4,
  parameter int MAX_RATE = 128
)(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate,
  input  logic                                    rate_stb,
  input  logic                                    strobe_in,
  input  logic [WIDTH-1:0]                        signal_in,
  output logic                                    strobe_out,
  output logic [WIDTH-1:0]                        signal_out
);

  // Internal word carries the worst case growth at MAX_RATE
  localparam int IW = WIDTH + cic_pkg::growth_bits(MAX_RATE, N);

  logic          comb_strobe;
  logic [IW-1:0] comb_data;
  logic          integ_strobe;
  logic          integ_strobe_out;
  logic [IW-1:0] integ_data;
  logic          round_strobe;
  logic [WIDTH-1:0] round_data;

  cic_comb #(.WIDTH(WIDTH), .N(N), .MAX_RATE(MAX_RATE)) u_comb (
    .clk         (clk),
    .reset       (reset),
    .strobe_in   (strobe_in),
    .signal_in   (signal_in),
    .comb_strobe (comb_strobe),
    .comb_data   (comb_data)
  );

  cic_strober #(.MAX_RATE(MAX_RATE)) u_strober (
    .clk          (clk),
    .reset        (reset),
    .rate         (rate),
    .rate_stb     (rate_stb),
    .comb_strobe  (comb_strobe),
    .integ_strobe (integ_strobe)
  );

  cic_integrator #(.WIDTH(WIDTH), .N(N), .MAX_RATE(MAX_RATE)) u_integrator (
    .clk              (clk),
    .reset            (reset),
    .comb_strobe      (comb_strobe),
    .comb_data        (comb_data),
    .integ_strobe     (integ_strobe),
    .integ_strobe_out (integ_strobe_out),
    .integ_data       (integ_data)
  );

  cic_round #(.WIDTH(WIDTH), .N(N), .MAX_RATE(MAX_RATE)) u_round (
    .clk          (clk),
    .reset        (reset),
    .rate         (rate),
    .in_strobe    (integ_strobe_out),
    .in_data      (integ_data),
    .round_strobe (round_strobe),
    .round_data   (round_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_out <= 1'b0;
      signal_out <= '0;
    end else begin
      strobe_out <= round_strobe;
      signal_out <= round_data;
    end
  end

endmodule

// ==== cic_round.sv ====
// Rate dependent normalizer
// Drops the bit growth of the current rate with rounding and saturation
`timescale 1ns/10ps

module cic_round #(
  parameter int WIDTH = 16,
  parameter int N = 4,
  parameter int MAX_RATE = 128
)(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate,
  input  logic                                    in_strobe,
  input  logic [WIDTH+cic_pkg::growth_bits(MAX_RATE, N)-1:0] in_data,
  output logic                                    round_strobe,
  output logic [WIDTH-1:0]                        round_data
);

  localparam int GROWTH = cic_pkg::growth_bits(MAX_RATE, N);
  localparam int IW = WIDTH + GROWTH;
  localparam int RW = cic_pkg::rate_bits(MAX_RATE);
  localparam int SW = $clog2(GROWTH + 1) + 1;

  logic [SW-1:0]        shift_tbl [0:MAX_RATE];
  logic [RW-1:0]        rate_idx;
  logic [SW-1:0]        g;
  logic [SW-1:0]        lshift;
  logic [IW-1:0]        aligned;
  logic signed [IW-1:0] ext;
  logic [IW:0]          half;
  logic [IW:0]          sum;
  logic signed [IW:0]   shifted;
  logic                 in_range;
  logic [WIDTH-1:0]     sat;

  for (genvar r = 0; r <= MAX_RATE; r++) begin : g_tbl
    assign shift_tbl[r] = SW'(cic_pkg::growth_bits(r, N));
  end

  assign rate_idx = (rate > RW'(MAX_RATE)) ? RW'(MAX_RATE) : rate;
  assign g        = shift_tbl[rate_idx];
  assign lshift   = SW'(GROWTH) - g;

  // Sign-extend from the top of the WIDTH+g bit slice
  assign aligned = in_data << lshift;
  assign ext     = $signed(aligned) >>> lshift;

  // Rates 0 and 1 have no growth, so the low WIDTH bits pass through
  assign half    = (cic_pkg::round_half && g != '0) ? (IW+1)'(1) << (g - SW'(1)) : '0;
  assign sum     = {ext[IW-1], ext} + half;
  assign shifted = $signed(sum) >>> g;

  assign in_range = (&shifted[IW:WIDTH-1]) || !(|shifted[IW:WIDTH-1]);
  assign sat      = in_range ? shifted[WIDTH-1:0] :
                    {shifted[IW], {(WIDTH-1){~shifted[IW]}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      round_strobe <= 1'b0;
    end else begin
      round_strobe <= in_strobe;
    end
  end

  always_ff @(posedge clk) begin
    round_data <= sat;
  end

endmodule

// ==== cic_integrator.sv ====
// CIC integrator section
// Holds the latest comb output and accumulates it at the output rate
`timescale 1ns/10ps

module cic_integrator #(
  parameter int WIDTH = 16,
  parameter int N = 4,
  parameter int MAX_RATE = 128
)(
  input  logic                clk,
  input  logic                reset,
  input  logic                comb_strobe,
  input  logic [WIDTH+cic_pkg::growth_bits(MAX_RATE, N)-1:0] comb_data,
  input  logic                integ_strobe,
  output logic                integ_strobe_out,
  output logic [WIDTH+cic_pkg::growth_bits(MAX_RATE, N)-1:0] integ_data
);

  localparam int IW = WIDTH + cic_pkg::growth_bits(MAX_RATE, N);

  logic [IW-1:0] sampler;
  logic          strobe_sampler;
  logic [IW-1:0] integrator [0:N-1];
  logic [N-1:0]  strobe_integ;

  always_ff @(posedge clk) begin
    if (comb_strobe) begin
      sampler <= comb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_sampler <= 1'b0;
      strobe_integ   <= '0;
      for (int i = 0; i < N; i++) begin
        integrator[i] <= '0;
      end
    end else begin
      strobe_sampler <= comb_strobe;
      strobe_integ   <= N'({strobe_integ, integ_strobe});
      // First stage sees the zero-stuffed stream, so it adds once per input
      if (strobe_sampler) begin
        integrator[0] <= integrator[0] + sampler;
      end
      for (int i = 1; i < N; i++) begin
        if (strobe_integ[i-1]) begin
          integrator[i] <= integrator[i] + integrator[i-1];
        end
      end
    end
  end

  assign integ_strobe_out = strobe_integ[N-1];
  assign integ_data       = integrator[N-1];

endmodule

// ==== cic_strober.sv ====
// Output rate strober
// Issues rate consecutive strobes after every comb output
`timescale 1ns/10ps

module cic_strober #(
  parameter int MAX_RATE = 128
)(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic [cic_pkg::rate_bits(MAX_RATE)-1:0] rate,
  input  logic                                    rate_stb,
  input  logic                                    comb_strobe,
  output logic                                    integ_strobe
);

  localparam int RW = cic_pkg::rate_bits(MAX_RATE);

  logic [RW-1:0] counter;

  // Idle when counter equals rate, counting when below it
  always_ff @(posedge clk) begin
    if (reset || rate_stb) begin
      counter <= rate;
    end else if (comb_strobe) begin
      counter <= rate - RW'(1);
    end else if (counter == '0) begin
      counter <= rate;
    end else if (counter < rate) begin
      counter <= counter - RW'(1);
    end
  end

  // Suppressed during a rate load so a stale count gives no strobe
  assign integ_strobe = (counter < rate) && !rate_stb;

endmodule

// ==== cic_comb.sv ====
// CIC comb section
// Sign-extends the input and runs N differentiators at the input rate
`timescale 1ns/10ps

module cic_comb #(
  parameter int WIDTH = 16,
  parameter int N = 4,
  parameter int MAX_RATE = 128
)(
  input  logic                clk,
  input  logic                reset,
  input  logic                strobe_in,
  input  logic [WIDTH-1:0]    signal_in,
  output logic                comb_strobe,
  output logic [WIDTH+cic_pkg::growth_bits(MAX_RATE, N)-1:0] comb_data
);

  localparam int IW = WIDTH + cic_pkg::growth_bits(MAX_RATE, N);

  logic [IW-1:0] signal_in_ext;
  logic [IW-1:0] delay [0:N-1];
  logic [IW-1:0] diff [0:N-1];
  logic [N-1:0]  strobe_diff;

  assign signal_in_ext = IW'($signed(signal_in));

  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_diff <= '0;
      for (int i = 0; i < N; i++) begin
        delay[i] <= '0;
        diff[i]  <= '0;
      end
    end else begin
      // Strobe follows the data one stage per cycle
      strobe_diff <= N'({strobe_diff, strobe_in});
      if (strobe_in) begin
        delay[0] <= signal_in_ext;
        diff[0]  <= signal_in_ext - delay[0];
      end
      for (int i = 1; i < N; i++) begin
        if (strobe_diff[i-1]) begin
          delay[i] <= diff[i-1];
          diff[i]  <= diff[i-1] - delay[i];
        end
      end
    end
  end

  assign comb_strobe = strobe_diff[N-1];
  assign comb_data   = diff[N-1];

endmodule

// ==== cic_pkg.sv ====
// CIC interpolator shared definitions
// Default sizes, width helper functions and rounding mode
package cic_pkg;

  localparam int DEF_WIDTH = 16;
  localparam int DEF_N = 4;
  localparam int DEF_MAX_RATE = 128;

  // Round half up when set, truncate otherwise
  localparam bit round_half = 1'b1;

  // Width needed to hold a rate value up to max_rate
  function automatic int rate_bits(input int max_rate);
    return $clog2(max_rate + 1);
  endfunction

  // Ceiling log2 of rate**(n-1), the bit growth of the filter
  function automatic int growth_bits(input int rate, input int n);
    longint unsigned prod;
    int bits;
    prod = 1;
    bits = 0;
    for (int i = 1; i < n; i++) begin
      prod = prod * longint'(rate);
    end
    for (int i = 0; i < 63; i++) begin
      if ((64'd1 << i) < prod) bits = i + 1;
    end
    return bits;
  endfunction

endpackage
